//--- files.f
design/ctrl_pkg.sv
design/axil_write_port.sv
design/axil_read_port.sv
design/ctrl_regfile.sv
design/ctrl_registers.sv
testbench/tb_ctrl_registers.sv

//--- Makefile
# Verilator build and run of the control-register testbench

VERILATOR ?= verilator
TOP       ?= tb_ctrl_registers
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j $(JOBS)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tb_ctrl_registers.sv
/*
 * Testbench for the control-register block.
 * Acts as an AXI4-Lite master with random gaps and back-pressure, predicts
 * every B and R response from a register model, and checks the level outputs.
 */

`default_nettype none

module tb_ctrl_registers;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 8;
  localparam int N_RAND = 20;
  localparam int N_STRESS = 24;
  // Worst gap plus handshakes plus a few back-pressure cycles
  localparam int TXN_CYCLES = 24;
  localparam int N_TXN = 3 + 2 * N_RAND + 3 + 16 + 3 * N_STRESS;
  localparam int WATCHDOG_CYCLES = 4 * (RESET_CYCLES + N_TXN * TXN_CYCLES);

  // Expected B and R responses
  typedef struct packed {
    ctrl_pkg::resp_t resp;
    logic            exit_ok;
  } b_exp_t;

  typedef struct packed {
    ctrl_pkg::data_t data;
    ctrl_pkg::resp_t resp;
  } r_exp_t;

  logic                 clk;
  logic                 reset;
  ctrl_pkg::axil_req_t  req;
  ctrl_pkg::axil_resp_t resp;
  ctrl_pkg::data_t      exit_lvl;
  ctrl_pkg::data_t      dram_base_lvl;
  ctrl_pkg::data_t      dram_end_lvl;

  logic [31:0]     lfsr_q = 32'hf37c_ee28;
  ctrl_pkg::data_t model_exit = '0;
  b_exp_t          exp_b[$];
  r_exp_t          exp_r[$];
  logic            b_valid_prev;
  int              checks = 0;
  int              errors = 0;
  int              test_err_start = 0;
  int              exp_pulses = 0;
  int              seen_pulses = 0;

  ctrl_registers DUT (
    .clk_i            (clk),
    .reset_i          (reset),
    .axil_req_i       (req),
    .axil_resp_o      (resp),
    .exit_o           (exit_lvl),
    .dram_base_addr_o (dram_base_lvl),
    .dram_end_addr_o  (dram_end_lvl)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  // Reference model, byte lanes selected by an expanded strobe mask
  function automatic ctrl_pkg::data_t merge_bytes(input ctrl_pkg::data_t old_v,
                                                  input ctrl_pkg::data_t d,
                                                  input ctrl_pkg::strb_t s);
    ctrl_pkg::data_t mask;
    mask = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    return (old_v & ~mask) | (d & mask);
  endfunction

  // Only word 0 takes writes
  function automatic b_exp_t ref_write(input ctrl_pkg::addr_t a);
    b_exp_t e;
    e.exit_ok = ((a >> 2) == 0);
    e.resp = e.exit_ok ? ctrl_pkg::RESP_OKAY : ctrl_pkg::RESP_SLVERR;
    return e;
  endfunction

  function automatic r_exp_t ref_read(input ctrl_pkg::addr_t a, input ctrl_pkg::data_t exit_v);
    r_exp_t e;
    e.data = '0;
    e.resp = ctrl_pkg::RESP_OKAY;
    case (a >> 2)
      0: e.data = exit_v;
      1: e.data = ctrl_pkg::DRAM_BASE_ADDR;
      2: e.data = ctrl_pkg::DRAM_BASE_ADDR + ctrl_pkg::DRAM_LENGTH;
      default: e.resp = ctrl_pkg::RESP_SLVERR;
    endcase
    return e;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s at %0t: got 0x%08h, expected 0x%08h", name, $time, got, exp);
    end
  endtask

  task automatic send_aw(input ctrl_pkg::addr_t a);
    int gap;
    gap = int'(rand_bits(3));
    repeat (gap) @(posedge clk);
    req.aw_addr  <= a;
    req.aw_valid <= 1'b1;
    @(posedge clk);
    while (!resp.aw_ready) @(posedge clk);
    req.aw_valid <= 1'b0;
  endtask

  task automatic send_w(input ctrl_pkg::data_t d, input ctrl_pkg::strb_t s);
    int gap;
    gap = int'(rand_bits(3));
    repeat (gap) @(posedge clk);
    req.w_data  <= d;
    req.w_strb  <= s;
    req.w_valid <= 1'b1;
    @(posedge clk);
    while (!resp.w_ready) @(posedge clk);
    req.w_valid <= 1'b0;
  endtask

  // AW and W race each other, then B under random ready
  task automatic write_txn(input ctrl_pkg::addr_t a, input ctrl_pkg::data_t d,
                           input ctrl_pkg::strb_t s);
    b_exp_t e;
    logic   done;
    e = ref_write(a);
    if (e.exit_ok) begin
      model_exit = merge_bytes(model_exit, d, s);
      exp_pulses++;
    end
    exp_b.push_back(e);
    fork
      send_aw(a);
      send_w(d, s);
    join
    done = 1'b0;
    while (!done) begin
      req.b_ready <= (rand_bits(2) != 0);
      @(posedge clk);
      done = resp.b_valid && req.b_ready;
    end
    req.b_ready <= 1'b0;
  endtask

  task automatic read_txn(input ctrl_pkg::addr_t a);
    int   gap;
    logic done;
    exp_r.push_back(ref_read(a, model_exit));
    gap = int'(rand_bits(3));
    repeat (gap) @(posedge clk);
    req.ar_addr  <= a;
    req.ar_valid <= 1'b1;
    @(posedge clk);
    while (!resp.ar_ready) @(posedge clk);
    req.ar_valid <= 1'b0;
    done = 1'b0;
    while (!done) begin
      req.r_ready <= (rand_bits(2) != 0);
      @(posedge clk);
      done = resp.r_valid && req.r_ready;
    end
    req.r_ready <= 1'b0;
  endtask

  task automatic end_test(input string name);
    repeat (2) @(posedge clk);
    $display("test %-14s %s, %0d errors", name,
             (errors == test_err_start) ? "ok" : "failed", errors - test_err_start);
    test_err_start = errors;
  endtask

  // Compare process for B, R and the exit pulse
  always @(posedge clk) begin : compare
    b_exp_t be;
    r_exp_t re;
    logic   pulse_exp;
    if (!reset) begin
      // Pulse rises together with b_valid of a good exit write
      pulse_exp = resp.b_valid && !b_valid_prev && exp_b.size() > 0 && exp_b[0].exit_ok;
      check_value("exit_o[0]", 32'(exit_lvl[0]), 32'(pulse_exp));
      if (exit_lvl[0]) seen_pulses++;
      if (resp.b_valid && req.b_ready) begin
        if (exp_b.size() == 0) begin
          errors++;
          $display("Write response at %0t with no write outstanding", $time);
        end else begin
          be = exp_b.pop_front();
          check_value("b_resp", 32'(resp.b_resp), 32'(be.resp));
        end
      end
      if (resp.r_valid && req.r_ready) begin
        if (exp_r.size() == 0) begin
          errors++;
          $display("Read response at %0t with no read outstanding", $time);
        end else begin
          re = exp_r.pop_front();
          check_value("r_data", resp.r_data, re.data);
          check_value("r_resp", 32'(resp.r_resp), 32'(re.resp));
        end
      end
    end
    b_valid_prev = resp.b_valid;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : main
    ctrl_pkg::data_t d;
    ctrl_pkg::addr_t wa;
    ctrl_pkg::addr_t ra;
    logic [1:0]      sel;
    ctrl_pkg::addr_t bad_addr [6];

    req = '0;
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    // Reset values over the bus and on the level outputs
    read_txn(ctrl_pkg::EXIT_OFFS);
    read_txn(ctrl_pkg::DRAM_BASE_OFFS);
    read_txn(ctrl_pkg::DRAM_END_OFFS);
    check_value("exit_o", exit_lvl, 32'h0);
    check_value("dram_base_addr_o", dram_base_lvl, ctrl_pkg::DRAM_BASE_ADDR);
    check_value("dram_end_addr_o", dram_end_lvl, ctrl_pkg::DRAM_BASE_ADDR + ctrl_pkg::DRAM_LENGTH);
    end_test("reset_values");

    for (int i = 0; i < N_RAND; i++) begin
      write_txn(ctrl_pkg::EXIT_OFFS, rand_bits(32), ctrl_pkg::strb_t'(rand_bits(4)));
      check_value("exit_o[31:1]", {exit_lvl[31:1], 1'b0}, {model_exit[30:0], 1'b0});
      read_txn(ctrl_pkg::EXIT_OFFS);
    end
    end_test("exit_writes");

    // Empty strobe still counts as a write, read-only target does not
    write_txn(ctrl_pkg::EXIT_OFFS, rand_bits(32), 4'h0);
    write_txn(ctrl_pkg::DRAM_BASE_OFFS, rand_bits(32), 4'hf);
    write_txn(ctrl_pkg::EXIT_OFFS, rand_bits(32), 4'hf);
    @(posedge clk);
    check_value("exit pulse count", seen_pulses, exp_pulses);
    end_test("exit_pulse");

    bad_addr[0] = ctrl_pkg::DRAM_BASE_OFFS;
    bad_addr[1] = ctrl_pkg::DRAM_END_OFFS;
    bad_addr[2] = 32'hc;
    bad_addr[3] = 32'h10;
    bad_addr[4] = 32'h100;
    // Bit 4 set keeps it outside the map
    bad_addr[5] = (rand_bits(32) | 32'h10) & 32'hffff_fffc;
    for (int i = 0; i < 6; i++) begin
      write_txn(bad_addr[i], rand_bits(32), 4'hf);
      read_txn(ctrl_pkg::EXIT_OFFS);
    end
    for (int i = 2; i < 6; i++) begin
      read_txn(bad_addr[i]);
    end
    check_value("dram_base_addr_o", dram_base_lvl, ctrl_pkg::DRAM_BASE_ADDR);
    check_value("dram_end_addr_o", dram_end_lvl, ctrl_pkg::DRAM_BASE_ADDR + ctrl_pkg::DRAM_LENGTH);
    end_test("bad_access");

    for (int i = 0; i < N_STRESS; i++) begin
      sel = 2'(rand_bits(2));
      case (sel)
        2'd0, 2'd1: wa = ctrl_pkg::EXIT_OFFS;
        2'd2: wa = ctrl_pkg::DRAM_END_OFFS;
        default: wa = 32'hc;
      endcase
      sel = 2'(rand_bits(2));
      ra = {28'h0, sel, 2'b00};
      // Keep the concurrent read off a register that is being written
      if (wa == ctrl_pkg::EXIT_OFFS && sel == 2'd0) ra = 32'hc;
      d = rand_bits(32);
      fork
        write_txn(wa, d, ctrl_pkg::strb_t'(rand_bits(4)));
        read_txn(ra);
      join
      read_txn(ctrl_pkg::EXIT_OFFS);
      check_value("exit_o[31:1]", {exit_lvl[31:1], 1'b0}, {model_exit[30:0], 1'b0});
    end
    check_value("exit pulse count", seen_pulses, exp_pulses);
    end_test("stress");

    if (exp_b.size() != 0 || exp_r.size() != 0) begin
      errors++;
      $display("Responses missing: %0d writes and %0d reads never completed",
               exp_b.size(), exp_r.size());
    end
    $display("Done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- design/ctrl_registers.sv
/*
 * Top of the control-register block.
 * Joins the AXI4-Lite write and read ports to the register file and
 * packs both ports' outputs into the response struct.
 */

`default_nettype none

module ctrl_registers (
  input  wire logic                clk_i,
  input  wire logic                reset_i,
  input  wire ctrl_pkg::axil_req_t axil_req_i,
  output ctrl_pkg::axil_resp_t     axil_resp_o,
  output ctrl_pkg::data_t          exit_o,
  output ctrl_pkg::data_t          dram_base_addr_o,
  output ctrl_pkg::data_t          dram_end_addr_o
);

  // Write channel
  logic              aw_ready;
  logic              w_ready;
  logic              b_valid;
  ctrl_pkg::resp_t   b_resp;
  logic              wr_en;
  ctrl_pkg::reg_wr_t wr;
  logic              wr_err;

  // Read channel
  logic              ar_ready;
  logic              r_valid;
  ctrl_pkg::data_t   r_data;
  ctrl_pkg::resp_t   r_resp;
  logic              rd_en;
  ctrl_pkg::addr_t   rd_addr;
  ctrl_pkg::reg_rd_t rd;

  axil_write_port i_write_port (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .axil_req_i (axil_req_i),
    .aw_ready_o (aw_ready),
    .w_ready_o  (w_ready),
    .b_valid_o  (b_valid),
    .b_resp_o   (b_resp),
    .wr_en_o    (wr_en),
    .wr_o       (wr),
    .wr_err_i   (wr_err)
  );

  axil_read_port i_read_port (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .axil_req_i (axil_req_i),
    .ar_ready_o (ar_ready),
    .r_valid_o  (r_valid),
    .r_data_o   (r_data),
    .r_resp_o   (r_resp),
    .rd_en_o    (rd_en),
    .rd_addr_o  (rd_addr),
    .rd_i       (rd)
  );

  ctrl_regfile i_regfile (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .wr_en_i          (wr_en),
    .wr_i             (wr),
    .wr_err_o         (wr_err),
    .rd_en_i          (rd_en),
    .rd_addr_i        (rd_addr),
    .rd_o             (rd),
    .exit_o           (exit_o),
    .dram_base_addr_o (dram_base_addr_o),
    .dram_end_addr_o  (dram_end_addr_o)
  );

  // Each port owns its own response fields
  assign axil_resp_o = '{
    aw_ready: aw_ready,
    w_ready:  w_ready,
    b_resp:   b_resp,
    b_valid:  b_valid,
    ar_ready: ar_ready,
    r_data:   r_data,
    r_resp:   r_resp,
    r_valid:  r_valid
  };

endmodule

`default_nettype wire

//--- design/ctrl_regfile.sv
/*
 * Control register storage with address decode and access checks.
 * Serves one write and one read per cycle and drives the register
 * values out as levels, with a write pulse folded into exit_o.
 */

`default_nettype none

module ctrl_regfile (
  input  wire logic              clk_i,
  input  wire logic              reset_i,
  input  wire logic              wr_en_i,
  input  wire ctrl_pkg::reg_wr_t wr_i,
  output logic                   wr_err_o,
  input  wire logic              rd_en_i,
  input  wire ctrl_pkg::addr_t   rd_addr_i,
  output ctrl_pkg::reg_rd_t      rd_o,
  output ctrl_pkg::data_t        exit_o,
  output ctrl_pkg::data_t        dram_base_addr_o,
  output ctrl_pkg::data_t        dram_end_addr_o
);

  ctrl_pkg::data_t exit_q;
  ctrl_pkg::data_t exit_d;
  ctrl_pkg::data_t dram_base_q;
  ctrl_pkg::data_t dram_end_q;
  logic            exit_pulse_q;
  logic            wr_exit;

  function automatic ctrl_pkg::reg_idx_t word_idx(input ctrl_pkg::addr_t a);
    return a[ctrl_pkg::REG_IDX_W+1:2];
  endfunction

  // Upper bits clear and the index names one of the three registers
  function automatic logic is_mapped(input ctrl_pkg::addr_t a);
    return (a[ctrl_pkg::ADDR_W-1:ctrl_pkg::REG_IDX_W+2] == '0) &&
           (word_idx(a) == word_idx(ctrl_pkg::EXIT_OFFS) ||
            word_idx(a) == word_idx(ctrl_pkg::DRAM_BASE_OFFS) ||
            word_idx(a) == word_idx(ctrl_pkg::DRAM_END_OFFS));
  endfunction

  // exit is the only writable register
  assign wr_exit  = is_mapped(wr_i.addr) && word_idx(wr_i.addr) == word_idx(ctrl_pkg::EXIT_OFFS);
  assign wr_err_o = !wr_exit;

  // Byte merge under the strobe
  always_comb begin
    exit_d = exit_q;
    for (int b = 0; b < ctrl_pkg::STRB_W; b++) begin
      if (wr_i.strb[b]) exit_d[8*b +: 8] = wr_i.data[8*b +: 8];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exit_q       <= '0;
      dram_base_q  <= ctrl_pkg::DRAM_BASE_ADDR;
      dram_end_q   <= ctrl_pkg::DRAM_BASE_ADDR + ctrl_pkg::DRAM_LENGTH;
      exit_pulse_q <= 1'b0;
    end else begin
      if (wr_en_i && wr_exit) exit_q <= exit_d;
      // High for one cycle after a committed exit write
      exit_pulse_q <= wr_en_i && wr_exit;
    end
  end

  // Combinational lookup, reads see the value before a same-cycle commit
  always_comb begin
    rd_o = '0;
    if (rd_en_i) begin
      rd_o.err = !is_mapped(rd_addr_i);
      if (!rd_o.err) begin
        if (word_idx(rd_addr_i) == word_idx(ctrl_pkg::EXIT_OFFS)) rd_o.data = exit_q;
        else if (word_idx(rd_addr_i) == word_idx(ctrl_pkg::DRAM_BASE_OFFS)) rd_o.data = dram_base_q;
        else rd_o.data = dram_end_q;
      end
    end
  end

  assign exit_o           = {exit_q[ctrl_pkg::DATA_W-2:0], exit_pulse_q};
  assign dram_base_addr_o = dram_base_q;
  assign dram_end_addr_o  = dram_end_q;

  // DRAM window is fixed for the whole run
  assert property (@(posedge clk_i) disable iff (reset_i)
    dram_base_q == ctrl_pkg::DRAM_BASE_ADDR &&
    dram_end_q == ctrl_pkg::DRAM_BASE_ADDR + ctrl_pkg::DRAM_LENGTH);

  // Enables from both ports are always driven
  assert property (@(posedge clk_i) disable iff (reset_i) !$isunknown({rd_en_i, wr_en_i}));

endmodule

`default_nettype wire

//--- design/axil_read_port.sv
/*
 * AXI4-Lite read channel front end.
 * Accepts one AR at a time, looks the address up in the register file
 * and holds the R response until the master is ready.
 */

`default_nettype none

module axil_read_port (
  input  wire logic                clk_i,
  input  wire logic                reset_i,
  input  wire ctrl_pkg::axil_req_t axil_req_i,
  output logic                     ar_ready_o,
  output logic                     r_valid_o,
  output ctrl_pkg::data_t          r_data_o,
  output ctrl_pkg::resp_t          r_resp_o,
  output logic                     rd_en_o,
  output ctrl_pkg::addr_t          rd_addr_o,
  input  wire ctrl_pkg::reg_rd_t   rd_i
);

  logic            r_valid_q;
  ctrl_pkg::data_t r_data_q;
  ctrl_pkg::resp_t r_resp_q;
  logic            ar_hs;

  // Only one read in flight
  assign ar_ready_o = !r_valid_q;
  assign ar_hs      = axil_req_i.ar_valid && ar_ready_o;

  // Lookup happens in the handshake cycle
  assign rd_en_o   = ar_hs;
  assign rd_addr_o = axil_req_i.ar_addr;

  assign r_valid_o = r_valid_q;
  assign r_data_o  = r_data_q;
  assign r_resp_o  = r_resp_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      r_valid_q <= 1'b0;
    end else if (ar_hs) begin
      r_valid_q <= 1'b1;
    end else if (r_valid_q && axil_req_i.r_ready) begin
      r_valid_q <= 1'b0;
    end
  end

  // Capture data and error flag from the register file
  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      r_data_q <= rd_i.data;
      r_resp_q <= rd_i.err ? ctrl_pkg::RESP_SLVERR : ctrl_pkg::RESP_OKAY;
    end
  end

  // R payload holds under back-pressure
  assert property (@(posedge clk_i) disable iff (reset_i)
    r_valid_o && !axil_req_i.r_ready |=>
      r_valid_o && $stable(r_data_o) && $stable(r_resp_o));

endmodule

`default_nettype wire

//--- design/axil_write_port.sv
/*
 * AXI4-Lite write channel front end.
 * Takes AW and W in any order, fires one register write once both are
 * held, then drives the B response until the master accepts it.
 */

`default_nettype none

module axil_write_port (
  input  wire logic                clk_i,
  input  wire logic                reset_i,
  input  wire ctrl_pkg::axil_req_t axil_req_i,
  output logic                     aw_ready_o,
  output logic                     w_ready_o,
  output logic                     b_valid_o,
  output ctrl_pkg::resp_t          b_resp_o,
  output logic                     wr_en_o,
  output ctrl_pkg::reg_wr_t        wr_o,
  input  wire logic                wr_err_i
);

  // Holding flags, one per channel
  logic aw_held_q;
  logic w_held_q;
  logic b_valid_q;

  // Held payload
  ctrl_pkg::addr_t aw_addr_q;
  ctrl_pkg::data_t w_data_q;
  ctrl_pkg::strb_t w_strb_q;
  ctrl_pkg::resp_t b_resp_q;

  logic aw_hs;
  logic w_hs;
  logic wr_fire;

  // Each channel stalls once it holds an item or while B is pending
  assign aw_ready_o = !aw_held_q && !b_valid_q;
  assign w_ready_o  = !w_held_q && !b_valid_q;

  assign aw_hs = axil_req_i.aw_valid && aw_ready_o;
  assign w_hs  = axil_req_i.w_valid && w_ready_o;

  // Both halves present, commit in this cycle
  assign wr_fire = aw_held_q && w_held_q;

  assign wr_en_o     = wr_fire;
  assign wr_o.addr   = aw_addr_q;
  assign wr_o.data   = w_data_q;
  assign wr_o.strb   = w_strb_q;

  assign b_valid_o = b_valid_q;
  assign b_resp_o  = b_resp_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      aw_held_q <= 1'b0;
      w_held_q  <= 1'b0;
      b_valid_q <= 1'b0;
    end else begin
      // Handshake and commit never coincide on the same channel
      if (aw_hs) begin
        aw_held_q <= 1'b1;
      end else if (wr_fire) begin
        aw_held_q <= 1'b0;
      end
      if (w_hs) begin
        w_held_q <= 1'b1;
      end else if (wr_fire) begin
        w_held_q <= 1'b0;
      end
      // B stays up until the master takes it
      if (wr_fire) begin
        b_valid_q <= 1'b1;
      end else if (b_valid_q && axil_req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      aw_addr_q <= axil_req_i.aw_addr;
    end
    if (w_hs) begin
      w_data_q <= axil_req_i.w_data;
      w_strb_q <= axil_req_i.w_strb;
    end
    // Register file answers in the commit cycle
    if (wr_fire) begin
      b_resp_q <= wr_err_i ? ctrl_pkg::RESP_SLVERR : ctrl_pkg::RESP_OKAY;
    end
  end

  // A stalled B response must not change
  assert property (@(posedge clk_i) disable iff (reset_i)
    b_valid_o && !axil_req_i.b_ready |=> b_valid_o && $stable(b_resp_o));

endmodule

`default_nettype wire

//--- design/ctrl_pkg.sv
/*
 * Shared definitions for the cluster control-register block.
 * Holds bus widths, the register map, DRAM constants and the AXI4-Lite
 * and register-access structs. Modules refer to them by scoped name.
 */

`default_nettype none

package ctrl_pkg;

  // Bus widths
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [STRB_W-1:0] strb_t;

  // Word index inside the map, taken from address bits 3:2
  localparam int unsigned REG_IDX_W = 2;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // Register map, byte offsets
  localparam addr_t EXIT_OFFS      = 32'h0000_0000;
  localparam addr_t DRAM_BASE_OFFS = 32'h0000_0004;
  localparam addr_t DRAM_END_OFFS  = 32'h0000_0008;

  // DRAM window reported to software
  localparam data_t DRAM_BASE_ADDR = 32'h8000_0000;
  localparam data_t DRAM_LENGTH    = 32'h4000_0000;

  // AXI response codes
  typedef logic [1:0] resp_t;
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Master to slave
  typedef struct packed {
    addr_t aw_addr;
    logic  aw_valid;
    data_t w_data;
    strb_t w_strb;
    logic  w_valid;
    logic  b_ready;
    addr_t ar_addr;
    logic  ar_valid;
    logic  r_ready;
  } axil_req_t;

  // Slave to master
  typedef struct packed {
    logic  aw_ready;
    logic  w_ready;
    resp_t b_resp;
    logic  b_valid;
    logic  ar_ready;
    data_t r_data;
    resp_t r_resp;
    logic  r_valid;
  } axil_resp_t;

  // Write request from the write port into the register file
  typedef struct packed {
    addr_t addr;
    data_t data;
    strb_t strb;
  } reg_wr_t;

  // Read answer from the register file
  typedef struct packed {
    data_t data;
    logic  err;
  } reg_rd_t;

endpackage

`default_nettype wire
